//--- Makefile
# Verilator build and run for the color mixer

VERILATOR ?= verilator
TOP       ?= tb_colmix
LINT_TOP  ?= colmix_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q -F '*** PASSED ***' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) \
		video_types_pkg.sv cpu_bus_pkg.sv pixel_if.sv layer_mux.sv \
		palette_ram.sv video_out.sv colmix_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- colmix_top.sv
// color mixer top: layer mux, palette RAM and color output joined by pixel_if
`timescale 1ns/1ps

module colmix_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    // CPU palette port
    input  cpu_bus_pkg::cpu_addr_t       cpu_addr,
    input  cpu_bus_pkg::cpu_data_t       cpu_dout,
    input  logic                         pal_cs,
    input  logic [1:0]                   dswn,
    output cpu_bus_pkg::cpu_data_t       cpu_din,
    // layer generators
    input  video_types_pkg::tmap_addr_t  tmap_addr,
    input  video_types_pkg::obj_pxl_t    obj_pxl,
    input  video_types_pkg::road_pxl_t   road_pxl,
    input  video_types_pkg::road_ctl_t   rc,
    input  logic                         shadow,
    input  logic                         sa,
    input  logic                         sb,
    input  logic                         fix,
    input  logic                         prelhbl,
    input  logic                         prelvbl,
    // video out
    output video_types_pkg::chan_t       red,
    output video_types_pkg::chan_t       green,
    output video_types_pkg::chan_t       blue,
    output logic                         lhbl,
    output logic                         lvbl
);

    // palette word, RAM to output stage
    video_types_pkg::pal_word_t pal_word;

    pixel_if pix_i (
        .pxl_cen (pxl_cen)
    );

    layer_mux layer_mux_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix       (pix_i.mux),
        .tmap_addr (tmap_addr),
        .obj_pxl   (obj_pxl),
        .road_pxl  (road_pxl),
        .rc        (rc),
        .shadow_in (shadow),
        .sa        (sa),
        .sb        (sb),
        .fix       (fix),
        .prelhbl   (prelhbl),
        .prelvbl   (prelvbl)
    );

    palette_ram palette_ram_i (
        .clk      (clk),
        .pix      (pix_i.ram),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .pal_cs   (pal_cs),
        .dswn     (dswn),
        .cpu_din  (cpu_din),
        .pal_word (pal_word)
    );

    video_out video_out_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (pix_i.out),
        .pal_word (pal_word),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

endmodule

//--- cpu_bus_pkg.sv
// CPU palette port address and data widths and the byte-lane type
package cpu_bus_pkg;

    // word address into the palette
    localparam int cpu_aw = 12;

    // 16-bit data bus, two byte lanes
    localparam int cpu_dw = 16;
    localparam int cpu_nbytes = cpu_dw / 8;

    typedef logic [cpu_aw-1:0] cpu_addr_t;

    typedef logic [cpu_dw-1:0] cpu_data_t;

    // bit 0 low byte, bit 1 high byte
    // active high, i.e. dswn inverted and qualified with pal_cs
    typedef logic [cpu_nbytes-1:0] byte_en_t;

endpackage

//--- layer_mux.sv
// layer mux: road sub-color mux, layer priority and registered palette index
`timescale 1ns/1ps

module layer_mux (
    input  logic                         clk,
    input  logic                         rst_n,
    pixel_if.mux                         pix,
    input  video_types_pkg::tmap_addr_t  tmap_addr,
    input  video_types_pkg::obj_pxl_t    obj_pxl,
    input  video_types_pkg::road_pxl_t   road_pxl,
    input  video_types_pkg::road_ctl_t   rc,
    input  logic                         shadow_in,
    input  logic                         sa,
    input  logic                         sb,
    input  logic                         fix,
    input  logic                         prelhbl,
    input  logic                         prelvbl
);

    // road color, same 11-bit space as the tile map color
    video_types_pkg::tmap_addr_t road_col;

    // sprite pixel of the previous strobe, used by the road select
    video_types_pkg::obj_pxl_t obj_q;

    logic road_sel;
    video_types_pkg::pal_addr_t addr_nxt;

    // road sub-color mux
    always_comb begin
        road_col[3:0] = road_pxl[3:0];
        // bits 5..4 steered by road control
        case (rc)
            2'd0,
            2'd1: road_col[5:4] = 2'b11;
            2'd2: road_col[5:4] = {1'b0, road_pxl[4]};
            default: road_col[5:4] = road_pxl[5:4];
        endcase
        // upper bits all follow rc[1]
        road_col[10:6] = {5{rc[1]}};
    end

    // road wins over tile map, never over fix
    // transparent sprite with rc[0] clear or no tile priority,
    // or the sprite code 10/0101 that punches through to road
    always_comb begin
        road_sel = !fix && (
            (obj_q[3:0] == 4'h0 && (!rc[0] || (!sa && !sb))) ||
            (obj_q[11:10] == 2'b10 && obj_q[3:0] == 4'b0101));
    end

    // palette index of the winning layer
    always_comb begin
        if (road_sel) begin
            addr_nxt = {2'b01, {3{road_col[7]}}, road_col[6:0]};
        end else if (sa || sb || fix) begin
            addr_nxt = {1'b0, tmap_addr};
        end else begin
            // sprite half, skips the shadow and priority bits 6..4
            addr_nxt = {1'b1, obj_pxl[13:7], obj_pxl[3:0]};
        end
    end

    // sprite history, payload only
    always_ff @(posedge clk) begin
        if (pix.pxl_cen) begin
            obj_q <= obj_pxl;
        end
    end

    // stage 1 registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix.pal_addr <= '0;
            pix.shadow   <= 1'b0;
            pix.lhbl     <= 1'b0;
            pix.lvbl     <= 1'b0;
        end else if (pix.pxl_cen) begin
            pix.pal_addr <= addr_nxt;
            pix.shadow   <= shadow_in;
            pix.lhbl     <= prelhbl;
            pix.lvbl     <= prelvbl;
        end
    end

    // index only moves on the edge that followed a strobe
    a_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(pix.pxl_cen) |-> $stable(pix.pal_addr)
    ) else $error("pal_addr changed without pxl_cen");

endmodule

//--- palette_ram.sv
// dual-port palette RAM: CPU byte-lane writes and read-back, video read port
`timescale 1ns/1ps

module palette_ram (
    input  logic                         clk,
    pixel_if.ram                         pix,
    input  cpu_bus_pkg::cpu_addr_t       cpu_addr,
    input  cpu_bus_pkg::cpu_data_t       cpu_dout,
    input  logic                         pal_cs,
    input  logic [1:0]                   dswn,
    output cpu_bus_pkg::cpu_data_t       cpu_din,
    output video_types_pkg::pal_word_t   pal_word
);

    // storage, contents undefined after reset
    video_types_pkg::pal_word_t mem [video_types_pkg::pal_words];

    // byte enables, strobes are active low
    cpu_bus_pkg::byte_en_t we;

    assign we = ~dswn & {2{pal_cs}};

    // CPU port
    // lanes written independently
    // read-back on every clock, old word on a same-clock write
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (we[1]) begin
            mem[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        cpu_din <= mem[cpu_addr];
    end

    // video port
    // one read per pixel, held until the next strobe
    // a colliding CPU write is seen one read later
    always_ff @(posedge clk) begin
        if (pix.pxl_cen) begin
            pal_word <= mem[pix.pal_addr];
        end
    end

    // lane strobes must be clean whenever the CPU selects the palette
    a_dswn_known: assert property (
        @(posedge clk)
        pal_cs |-> !$isunknown(dswn)
    ) else $error("dswn unknown during palette access");

endmodule

//--- pixel_if.sv
// pixel pipeline interface: strobe, palette index, shadow flag, blanking levels
`timescale 1ns/1ps

interface pixel_if (
    input logic pxl_cen
);

    // palette index from the layer mux
    video_types_pkg::pal_addr_t pal_addr;

    // sprite shadow request, same pixel as pal_addr
    logic shadow;

    // blank levels, low means blanked, one strobe behind the inputs
    logic lhbl;
    logic lvbl;

    // layer mux side
    modport mux (
        input  pxl_cen,
        output pal_addr,
        output shadow,
        output lhbl,
        output lvbl
    );

    // palette video port
    modport ram (
        input pxl_cen,
        input pal_addr
    );

    // color output stage
    modport out (
        input pxl_cen,
        input shadow,
        input lhbl,
        input lvbl
    );

endinterface

//--- src.f
video_types_pkg.sv
cpu_bus_pkg.sv
pixel_if.sv
layer_mux.sv
palette_ram.sv
video_out.sv
colmix_top.sv
tb_colmix.sv

//--- tb_colmix.sv
// color mixer testbench: clock, reset, palette model, stimulus, assertions, timeout
`timescale 1ns/1ps

module tb_colmix;

    // test sizes, in writes or pixels
    localparam int n_cpu = 16;
    localparam int n_tmap = 64;
    localparam int n_sprite = 64;
    localparam int n_road = 128;
    localparam int n_shadow = 64;
    localparam int n_blank = 96;
    localparam int n_pix = n_tmap + n_sprite + n_road + n_shadow + n_blank;
    localparam int drain_len = 2 * (video_types_pkg::pipe_dly + 2);
    // reset, palette fill, cpu tests, two clocks per pixel, drains
    localparam int run_len = 8 + video_types_pkg::pal_words + 2 + 4 * n_cpu
                             + 2 * n_pix + 5 * drain_len;
    localparam int cycle_limit = run_len * 3 / 2;

    logic clk;
    logic rst_n;
    logic pxl_cen;
    cpu_bus_pkg::cpu_addr_t cpu_addr;
    cpu_bus_pkg::cpu_data_t cpu_dout;
    logic pal_cs;
    logic [1:0] dswn;
    cpu_bus_pkg::cpu_data_t cpu_din;
    video_types_pkg::tmap_addr_t tmap_addr;
    video_types_pkg::obj_pxl_t obj_pxl;
    video_types_pkg::road_pxl_t road_pxl;
    video_types_pkg::road_ctl_t rc;
    logic shadow;
    logic sa;
    logic sb;
    logic fix;
    logic prelhbl;
    logic prelvbl;
    video_types_pkg::chan_t red;
    video_types_pkg::chan_t green;
    video_types_pkg::chan_t blue;
    logic lhbl;
    logic lvbl;

    // palette as the testbench wrote it
    video_types_pkg::pal_word_t pal_model [video_types_pkg::pal_words];
    video_types_pkg::obj_pxl_t prev_obj;

    // expected pixel {valid, lhbl, lvbl, rgb}, one entry per strobe in flight
    logic [17:0] cur_exp;
    logic [17:0] exp_pipe [video_types_pkg::pipe_dly];
    logic [17:0] exp_head;
    logic exp_chk;

    // cpu read-back check
    logic rb_check;
    cpu_bus_pkg::cpu_data_t rb_exp;

    integer seed = 32'ha4b;
    string test_name;
    int err_cnt;
    int chk_cnt;
    int err_mark;
    int chk_mark;
    int pass_tests;
    int fail_tests;
    int cycles;

    colmix_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .pal_cs    (pal_cs),
        .dswn      (dswn),
        .cpu_din   (cpu_din),
        .tmap_addr (tmap_addr),
        .obj_pxl   (obj_pxl),
        .road_pxl  (road_pxl),
        .rc        (rc),
        .shadow    (shadow),
        .sa        (sa),
        .sb        (sb),
        .fix       (fix),
        .prelhbl   (prelhbl),
        .prelvbl   (prelvbl),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // pixel strobe on every second clock
    always @(posedge clk) begin
        #1;
        pxl_cen = ~pxl_cen;
    end

    // palette index from the layer rules
    function automatic video_types_pkg::pal_addr_t expect_addr(
        input video_types_pkg::tmap_addr_t tm,
        input video_types_pkg::obj_pxl_t ob,
        input video_types_pkg::obj_pxl_t prv,
        input video_types_pkg::road_pxl_t rd,
        input video_types_pkg::road_ctl_t rcv,
        input logic sav,
        input logic sbv,
        input logic fx
    );
        logic [10:0] rcol;
        logic take_road;
        rcol[3:0] = rd[3:0];
        if (!rcv[1]) begin
            rcol[5:4] = 2'b11;
        end else if (!rcv[0]) begin
            rcol[5:4] = {1'b0, rd[4]};
        end else begin
            rcol[5:4] = rd[5:4];
        end
        rcol[10:6] = rcv[1] ? 5'h1f : 5'h00;
        // previous strobe's sprite decides
        take_road = !fx && ((prv[3:0] == 4'h0 && (!rcv[0] || (!sav && !sbv)))
                            || (prv[11:10] == 2'b10 && prv[3:0] == 4'h5));
        if (take_road) begin
            return {2'b01, {3{rcol[7]}}, rcol[6:0]};
        end
        if (sav || sbv || fx) begin
            return {1'b0, tm};
        end
        return {1'b1, ob[13:7], ob[3:0]};
    endfunction

    // RGB555 from a palette entry
    function automatic video_types_pkg::rgb_t expect_rgb(
        input video_types_pkg::pal_word_t w,
        input logic sh
    );
        video_types_pkg::chan_t r;
        video_types_pkg::chan_t g;
        video_types_pkg::chan_t b;
        r = {w[3:0], w[12]};
        g = {w[7:4], w[13]};
        b = {w[11:8], w[14]};
        // shadow keeps three quarters, bit 15 opts out
        if (sh && !w[15]) begin
            r = r - r / 5'd4;
            g = g - g / 5'd4;
            b = b - b / 5'd4;
        end
        return {r, g, b};
    endfunction

    task automatic wait_strobe();
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark = err_cnt;
        chk_mark = chk_cnt;
    endtask

    task automatic end_test();
        if (chk_cnt == chk_mark) begin
            $display("test %s: FAIL, no check was reached", test_name);
            fail_tests++;
        end else if (err_cnt != err_mark) begin
            $display("test %s: FAIL, %0d errors", test_name, err_cnt - err_mark);
            fail_tests++;
        end else begin
            $display("test %s: ok, %0d checks", test_name, chk_cnt - chk_mark);
            pass_tests++;
        end
    endtask

    // whole palette, all lanes, one word per clock
    task automatic fill_palette();
        integer r;
        video_types_pkg::pal_addr_t addr;
        for (int a = 0; a < video_types_pkg::pal_words; a++) begin
            r = $random(seed);
            addr = a[11:0];
            @(posedge clk);
            #1;
            cpu_addr = addr;
            cpu_dout = r[15:0] ^ {addr[3:0], addr};
            pal_cs = 1'b1;
            dswn = 2'b00;
            pal_model[addr] = r[15:0] ^ {addr[3:0], addr};
        end
        @(posedge clk);
        #1;
        pal_cs = 1'b0;
        dswn = 2'b11;
    endtask

    // write, then expect the merged word on cpu_din one clock later
    task automatic write_readback(
        input cpu_bus_pkg::cpu_addr_t addr,
        input cpu_bus_pkg::cpu_data_t data,
        input logic [1:0] lanes_n
    );
        @(posedge clk);
        #1;
        cpu_addr = addr;
        cpu_dout = data;
        pal_cs = 1'b1;
        dswn = lanes_n;
        if (!lanes_n[0]) pal_model[addr][7:0] = data[7:0];
        if (!lanes_n[1]) pal_model[addr][15:8] = data[15:8];
        // write edge
        @(posedge clk);
        #1;
        pal_cs = 1'b0;
        dswn = 2'b11;
        // read edge
        @(posedge clk);
        #1;
        rb_exp = pal_model[addr];
        rb_check = 1'b1;
        @(posedge clk);
        #1;
        rb_check = 1'b0;
    endtask

    task automatic run_cpu();
        integer r;
        begin_test("cpu_byte_lanes");
        for (int i = 0; i < n_cpu; i++) begin
            r = $random(seed);
            write_readback(r[27:16], r[15:0], i[1:0]);
        end
        end_test();
    endtask

    // one pixel for the next strobe, and its expected output
    task automatic send_pixel(
        input video_types_pkg::tmap_addr_t tm,
        input video_types_pkg::obj_pxl_t ob,
        input video_types_pkg::road_pxl_t rd,
        input video_types_pkg::road_ctl_t rcv,
        input logic sh,
        input logic sav,
        input logic sbv,
        input logic fx,
        input logic hb,
        input logic vb
    );
        video_types_pkg::pal_addr_t addr;
        video_types_pkg::rgb_t col;
        wait_strobe();
        #1;
        tmap_addr = tm;
        obj_pxl = ob;
        road_pxl = rd;
        rc = rcv;
        shadow = sh;
        sa = sav;
        sb = sbv;
        fix = fx;
        prelhbl = hb;
        prelvbl = vb;
        addr = expect_addr(tm, ob, prev_obj, rd, rcv, sav, sbv, fx);
        col = (hb && vb) ? expect_rgb(pal_model[addr], sh) : '0;
        cur_exp = {1'b1, hb, vb, col};
        prev_obj = ob;
    endtask

    // let the last pixel reach the output before the test closes
    task automatic drain();
        wait_strobe();
        #1;
        cur_exp = '0;
        repeat (video_types_pkg::pipe_dly + 1) wait_strobe();
    endtask

    // mode 0 tile map, 1 sprite, 2 road, 3 shadow, 4 blanking
    task automatic run_pixels(input string name, input int n, input int mode);
        integer ra;
        integer rb;
        video_types_pkg::obj_pxl_t ob;
        logic [2:0] ctl;
        logic sh;
        logic hb;
        logic vb;
        begin_test(name);
        for (int i = 0; i < n; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            ob = rb[13:0];
            // opaque sprite, off the road punch code
            if (ob[3:0] == 4'h0 || ob[3:0] == 4'h5) ob[3:0] = 4'ha;
            ctl = 3'b000;
            sh = 1'b0;
            hb = 1'b1;
            vb = 1'b1;
            case (mode)
                0: ctl = (rb[16:14] == 3'b000) ? 3'b100 : rb[16:14];
                2: begin
                    ctl = {1'b0, rb[15:14]};
                    // transparent sprite or punch code, alternating at random
                    if (rb[17]) begin
                        ob[3:0] = 4'h0;
                    end else begin
                        ob[11:10] = 2'b10;
                        ob[3:0] = 4'h5;
                    end
                end
                3: sh = rb[18];
                4: begin
                    ob = rb[13:0];
                    ctl = rb[16:14];
                    sh = rb[18];
                    hb = (rb[21:20] != 2'b00);
                    vb = (rb[23:22] != 2'b00);
                end
                default: ;
            endcase
            send_pixel(ra[10:0], ob, ra[18:11], ra[20:19], sh, ctl[0], ctl[1], ctl[2],
                       hb, vb);
        end
        drain();
        end_test();
    endtask

    // expected values follow the pipeline strobe by strobe
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < video_types_pkg::pipe_dly; i++) begin
                exp_pipe[i] <= '0;
            end
        end else if (pxl_cen) begin
            exp_pipe[0] <= cur_exp;
            for (int i = 1; i < video_types_pkg::pipe_dly; i++) begin
                exp_pipe[i] <= exp_pipe[i-1];
            end
        end
    end

    assign exp_head = exp_pipe[video_types_pkg::pipe_dly-1];
    // compare between strobes, where outputs hold
    assign exp_chk = !pxl_cen && exp_head[17];

    always @(posedge clk) begin
        if (rst_n && exp_chk) chk_cnt = chk_cnt + 2;
        if (rst_n && rb_check) chk_cnt = chk_cnt + 1;
    end

    a_rgb: assert property (@(posedge clk) disable iff (!rst_n)
        exp_chk |-> {red, green, blue} == exp_head[14:0])
        else begin
            $display("MISMATCH %s rgb expected %h actual %h", test_name, exp_head[14:0],
                     {red, green, blue});
            err_cnt++;
        end

    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        exp_chk |-> {lhbl, lvbl} == exp_head[16:15])
        else begin
            $display("MISMATCH %s blank expected %b actual %b", test_name, exp_head[16:15],
                     {lhbl, lvbl});
            err_cnt++;
        end

    a_readback: assert property (@(posedge clk) disable iff (!rst_n)
        rb_check |-> cpu_din == rb_exp)
        else begin
            $display("MISMATCH %s cpu_din expected %h actual %h", test_name, rb_exp, cpu_din);
            err_cnt++;
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        pxl_cen = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        pal_cs = 1'b0;
        dswn = 2'b11;
        tmap_addr = '0;
        obj_pxl = '0;
        road_pxl = '0;
        rc = '0;
        shadow = 1'b0;
        sa = 1'b0;
        sb = 1'b0;
        fix = 1'b0;
        prelhbl = 1'b1;
        prelvbl = 1'b1;
        prev_obj = '0;
        cur_exp = '0;
        rb_check = 1'b0;
        rb_exp = '0;
        test_name = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fill_palette();
        run_cpu();
        run_pixels("tmap_priority", n_tmap, 0);
        run_pixels("sprite_layer", n_sprite, 1);
        run_pixels("road_select", n_road, 2);
        run_pixels("shadow_dim", n_shadow, 3);
        run_pixels("blanking", n_blank, 4);
        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 pass_tests, fail_tests, chk_cnt, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- video_out.sv
// color output: RGB555 unpack, shadow dimming and blank gating
`timescale 1ns/1ps

module video_out (
    input  logic                         clk,
    input  logic                         rst_n,
    pixel_if.out                         pix,
    input  video_types_pkg::pal_word_t   pal_word,
    output video_types_pkg::chan_t       red,
    output video_types_pkg::chan_t       green,
    output video_types_pkg::chan_t       blue,
    output logic                         lhbl,
    output logic                         lvbl
);

    // {shadow, lhbl, lvbl} delayed to line up with the palette word
    // the layer mux and this output register take the other two strobes
    logic [2:0] stage_q [video_types_pkg::pipe_dly-2];

    // unpacked channels, high nibble then the low bit
    video_types_pkg::chan_t r_pal;
    video_types_pkg::chan_t g_pal;
    video_types_pkg::chan_t b_pal;

    video_types_pkg::rgb_t rgb_pal;
    video_types_pkg::rgb_t rgb_dim;
    video_types_pkg::rgb_t rgb_sel;

    logic shadow_d;
    logic lhbl_d;
    logic lvbl_d;
    logic dim_en;

    // three quarters of the channel
    function automatic video_types_pkg::chan_t dim(input video_types_pkg::chan_t c);
        return c - (c >> 2);
    endfunction

    assign r_pal = {pal_word[3:0], pal_word[12]};
    assign g_pal = {pal_word[7:4], pal_word[13]};
    assign b_pal = {pal_word[11:8], pal_word[14]};

    assign rgb_pal = {r_pal, g_pal, b_pal};
    assign rgb_dim = {dim(r_pal), dim(g_pal), dim(b_pal)};

    // last tap of the delay line
    assign {shadow_d, lhbl_d, lvbl_d} = stage_q[video_types_pkg::pipe_dly-3];

    // bit 15 set marks entries that ignore shadow
    assign dim_en = shadow_d && !pal_word[15];
    assign rgb_sel = dim_en ? rgb_dim : rgb_pal;

    // side-band delay line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < video_types_pkg::pipe_dly - 2; i++) begin
                stage_q[i] <= 3'b000;
            end
        end else if (pix.pxl_cen) begin
            stage_q[0] <= {pix.shadow, pix.lhbl, pix.lvbl};
            for (int i = 1; i < video_types_pkg::pipe_dly - 2; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // output register, black during either blank
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
        end else if (pix.pxl_cen) begin
            if (lhbl_d && lvbl_d) begin
                {red, green, blue} <= rgb_sel;
            end else begin
                {red, green, blue} <= '0;
            end
            lhbl <= lhbl_d;
            lvbl <= lvbl_d;
        end
    end

    // no color leaks into horizontal blank
    a_hblank_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !lhbl |-> (red == '0 && green == '0 && blue == '0)
    ) else $error("color out during horizontal blank");

endmodule

//--- video_types_pkg.sv
// pixel, palette, color and layer types, plus the pixel pipeline depth
package video_types_pkg;

    // palette geometry, 4k entries of 16 bits
    localparam int pal_aw = 12;
    localparam int pal_words = 1 << pal_aw;
    localparam int pal_dw = 16;

    // one color channel, three per pixel
    localparam int chan_w = 5;

    // layer generator pixel widths
    localparam int tmap_w = 11;
    localparam int obj_w = 14;
    localparam int road_w = 8;
    localparam int rc_w = 2;

    // pxl_cen strobes from layer inputs to rgb out, counted inclusive
    localparam int pipe_dly = 3;

    // palette index: bit 11 sprite half, bit 10 road entries
    typedef logic [pal_aw-1:0] pal_addr_t;

    // {no-shadow, low bits b/g/r, high nibbles b/g/r}
    typedef logic [pal_dw-1:0] pal_word_t;

    typedef logic [chan_w-1:0] chan_t;

    // red in the top bits, blue at the bottom
    typedef logic [3*chan_w-1:0] rgb_t;

    // layer inputs
    typedef logic [tmap_w-1:0] tmap_addr_t;
    typedef logic [obj_w-1:0] obj_pxl_t;
    typedef logic [road_w-1:0] road_pxl_t;
    typedef logic [rc_w-1:0] road_ctl_t;

endpackage
